/* hw/isa_pkg.sv */
package isa_pkg;

    typedef logic [63:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  regnum_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor
    } alu_op_t;

    localparam int num_regs = 32;

    // Primary opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_addi    = 6'h08;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;
    localparam opcode_t op_daddi   = 6'h18;
    localparam opcode_t op_daddiu  = 6'h19;

    // SPECIAL function codes
    localparam funct_t fn_sll    = 6'h00;
    localparam funct_t fn_srl    = 6'h02;
    localparam funct_t fn_add    = 6'h20;
    localparam funct_t fn_addu   = 6'h21;
    localparam funct_t fn_sub    = 6'h22;
    localparam funct_t fn_subu   = 6'h23;
    localparam funct_t fn_and    = 6'h24;
    localparam funct_t fn_or     = 6'h25;
    localparam funct_t fn_xor    = 6'h26;
    localparam funct_t fn_nor    = 6'h27;
    localparam funct_t fn_slt    = 6'h2a;
    localparam funct_t fn_sltu   = 6'h2b;
    localparam funct_t fn_dadd   = 6'h2c;
    localparam funct_t fn_daddu  = 6'h2d;
    localparam funct_t fn_dsub   = 6'h2e;
    localparam funct_t fn_dsubu  = 6'h2f;
    localparam funct_t fn_dsll   = 6'h38;
    localparam funct_t fn_dsrl   = 6'h3a;
    localparam funct_t fn_dsll32 = 6'h3c;
    localparam funct_t fn_dsrl32 = 6'h3e;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

    typedef enum logic [1:0] {
        src2_reg,
        src2_sext,
        src2_zext
    } src2_sel_t;

    typedef enum logic [1:0] {
        slt_none,
        slt_signed,
        slt_unsigned
    } slt_type_t;

    typedef enum logic [1:0] {
        cut_full,
        cut_sign32,
        cut_zero32
    } cut32_t;

    typedef enum logic [1:0] {
        plus32_none,
        plus32_left,
        plus32_right
    } plus32_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_ex,
        fwd_wb
    } forward_type_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::data_t    a_data;
        isa_pkg::data_t    b_data;
        isa_pkg::regnum_t  w_regnum;
        isa_pkg::regnum_t  rs_num;
        isa_pkg::regnum_t  rt_num;
        logic [15:0]       imm;
        isa_pkg::shamt_t   shamt;
        isa_pkg::alu_op_t  alu_op;
        src2_sel_t         alu_src2;
        slt_type_t         slt_type;
        cut32_t            cut_alu_out32;
        logic              shift_right;
        logic              cut_shifter_out32;
        plus32_t           shifter_plus32;
        logic              alu_shifter_src; // 1 picks the shifter
        logic              lui;
        logic              ignore_overflow;
        logic              write_enable;
    } id_regs_t;

    typedef struct packed {
        logic             valid;
        isa_pkg::data_t   out;
        isa_pkg::regnum_t w_regnum;
        logic             overflow;
        logic             write_enable;
    } ex_regs_t;

    typedef struct packed {
        logic             valid;
        isa_pkg::data_t   data;
        isa_pkg::regnum_t w_regnum;
        logic             overflow;
        logic             write_enable;
    } wb_regs_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/10ps

module alu (
    input  isa_pkg::data_t   a,
    input  isa_pkg::data_t   b,
    input  isa_pkg::alu_op_t alu_op,
    input  logic             word,
    output isa_pkg::data_t   out,
    output logic             overflow,
    output logic             zero,
    output logic             negative,
    output logic             borrow_out
);
    import isa_pkg::*;

    logic        subtract;
    data_t       b_add;
    logic [64:0] sum;

    // One adder for add and sub
    assign subtract = (alu_op == alu_sub);
    assign b_add    = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_add} + {64'b0, subtract};

    always_comb begin
        case (alu_op)
            alu_and: out = a & b;
            alu_or:  out = a | b;
            alu_xor: out = a ^ b;
            alu_nor: out = ~(a | b);
            default: out = sum[63:0];
        endcase
    end

    // Signed overflow at the operation's own width
    assign overflow = word ? (a[31] == b_add[31]) && (sum[31] != a[31])
                           : (a[63] == b_add[63]) && (sum[63] != a[63]);

    assign zero       = (out == '0);
    assign negative   = out[63];
    assign borrow_out = subtract & ~sum[64]; // No carry out of a - b means a < b
endmodule

/* hw/barrel_shifter.sv */
`timescale 1ns/10ps

module barrel_shifter (
    input  isa_pkg::data_t  data,
    input  isa_pkg::shamt_t shamt,
    input  logic            shift_right,
    output isa_pkg::data_t  out
);
    import isa_pkg::*;

    data_t level [6];

    // Each level shifts by a power of two
    always_comb begin
        level[0] = data;
        for (int i = 0; i < 5; i++) begin
            if (!shamt[i]) begin
                level[i + 1] = level[i];
            end else if (shift_right) begin
                level[i + 1] = level[i] >> (1 << i);
            end else begin
                level[i + 1] = level[i] << (1 << i);
            end
        end
    end

    assign out = level[5];
endmodule

/* hw/regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic             clock,
    input  logic             reset,
    input  isa_pkg::regnum_t ra_num,
    input  isa_pkg::regnum_t rb_num,
    output isa_pkg::data_t   ra_data,
    output isa_pkg::data_t   rb_data,
    input  logic             w_enable,
    input  isa_pkg::regnum_t w_regnum,
    input  isa_pkg::data_t   w_data
);
    import isa_pkg::*;

    data_t regs [num_regs];
    logic  writing;

    assign writing = w_enable && (w_regnum != '0); // r0 stays zero

    // Write-through so a same-cycle read sees the new value
    assign ra_data = (writing && (w_regnum == ra_num)) ? w_data : regs[ra_num];
    assign rb_data = (writing && (w_regnum == rb_num)) ? w_data : regs[rb_num];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[w_regnum] <= w_data;
        end
    end
endmodule

/* hw/forward_unit.sv */
`timescale 1ns/10ps

module forward_unit (
    input  pipe_pkg::id_regs_t      id_regs,
    input  pipe_pkg::ex_regs_t      ex_regs,
    input  pipe_pkg::wb_regs_t      wb_regs,
    output pipe_pkg::forward_type_t forward_a,
    output pipe_pkg::forward_type_t forward_b
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic ex_writes;
    logic wb_writes;

    function automatic forward_type_t pick(regnum_t src, logic ex_hit, logic wb_hit);
        if (src == '0) begin
            return fwd_reg;
        end else if (ex_hit) begin
            return fwd_ex;        // Youngest producer wins
        end else if (wb_hit) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    // An overflowed result never reaches the register file
    assign ex_writes = ex_regs.valid && ex_regs.write_enable && !ex_regs.overflow;
    assign wb_writes = wb_regs.valid && wb_regs.write_enable;

    assign forward_a = pick(id_regs.rs_num,
                            ex_writes && (ex_regs.w_regnum == id_regs.rs_num),
                            wb_writes && (wb_regs.w_regnum == id_regs.rs_num));
    assign forward_b = pick(id_regs.rt_num,
                            ex_writes && (ex_regs.w_regnum == id_regs.rt_num),
                            wb_writes && (wb_regs.w_regnum == id_regs.rt_num));
endmodule

/* hw/core_id.sv */
`timescale 1ns/10ps

module core_id (
    input  logic               clock,
    input  logic               reset,
    input  logic               flush,
    input  logic               inst_valid,
    input  isa_pkg::inst_t     inst,
    output isa_pkg::regnum_t   ra_num,
    output isa_pkg::regnum_t   rb_num,
    input  isa_pkg::data_t     ra_data,
    input  isa_pkg::data_t     rb_data,
    output pipe_pkg::id_regs_t id_regs
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regnum_t  rs;
    regnum_t  rt;
    regnum_t  rd;
    logic     legal;
    logic     dest_rd;
    id_regs_t id_next;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign funct  = inst[5:0];
    assign ra_num = rs;
    assign rb_num = rt;

    always_comb begin
        id_next = '0;
        id_next.ignore_overflow = 1'b1; // Only the trapping adds clear it
        legal   = 1'b1;
        dest_rd = 1'b0;
        case (opcode)
            op_special: begin
                dest_rd = 1'b1;
                case (funct)
                    fn_add, fn_addu, fn_sub, fn_subu,
                    fn_dadd, fn_daddu, fn_dsub, fn_dsubu: begin
                        id_next.alu_op          = funct[1] ? alu_sub : alu_add;
                        id_next.ignore_overflow = funct[0]; // Odd codes are unsigned
                        if (!funct[3]) begin
                            id_next.cut_alu_out32 = cut_sign32;
                        end
                    end
                    fn_and: id_next.alu_op = alu_and;
                    fn_or:  id_next.alu_op = alu_or;
                    fn_xor: id_next.alu_op = alu_xor;
                    fn_nor: id_next.alu_op = alu_nor;
                    fn_slt, fn_sltu: begin
                        id_next.alu_op   = alu_sub;
                        id_next.slt_type = funct[0] ? slt_unsigned : slt_signed;
                    end
                    fn_sll, fn_srl: begin
                        id_next.alu_shifter_src   = 1'b1;
                        id_next.shift_right       = funct[1];
                        id_next.cut_shifter_out32 = 1'b1;
                    end
                    fn_dsll, fn_dsrl, fn_dsll32, fn_dsrl32: begin
                        id_next.alu_shifter_src = 1'b1;
                        id_next.shift_right     = funct[1];
                        if (funct[2]) begin
                            id_next.shifter_plus32 = funct[1] ? plus32_right : plus32_left;
                        end
                    end
                    default: legal = 1'b0;
                endcase
            end
            op_addi, op_addiu, op_daddi, op_daddiu: begin
                id_next.alu_src2        = src2_sext;
                id_next.ignore_overflow = opcode[0];
                if (!opcode[4]) begin
                    id_next.cut_alu_out32 = cut_sign32; // Word forms
                end
            end
            op_slti, op_sltiu: begin
                id_next.alu_op   = alu_sub;
                id_next.alu_src2 = src2_sext;
                id_next.slt_type = opcode[0] ? slt_unsigned : slt_signed;
            end
            op_andi: begin
                id_next.alu_op   = alu_and;
                id_next.alu_src2 = src2_zext;
            end
            op_ori: begin
                id_next.alu_op   = alu_or;
                id_next.alu_src2 = src2_zext;
            end
            op_xori: begin
                id_next.alu_op   = alu_xor;
                id_next.alu_src2 = src2_zext;
            end
            op_lui:  id_next.lui = 1'b1;
            default: legal = 1'b0;
        endcase

        id_next.valid        = inst_valid && legal;
        id_next.a_data       = ra_data;
        id_next.b_data       = rb_data;
        id_next.w_regnum     = dest_rd ? rd : rt;
        id_next.rs_num       = rs;
        id_next.rt_num       = rt;
        id_next.imm          = inst[15:0];
        id_next.shamt        = inst[10:6];
        id_next.write_enable = id_next.valid && (id_next.w_regnum != '0);
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            id_regs <= '0;
        end else if (flush) begin
            id_regs <= '0;
        end else begin
            id_regs <= id_next;
        end
    end
endmodule

/* hw/core_ex.sv */
`timescale 1ns/10ps

module core_ex (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    flush,
    input  pipe_pkg::id_regs_t      id_regs,
    input  isa_pkg::data_t          wb_data,
    input  pipe_pkg::forward_type_t forward_a,
    input  pipe_pkg::forward_type_t forward_b,
    output pipe_pkg::ex_regs_t      ex_regs
);
    import isa_pkg::*;
    import pipe_pkg::*;

    data_t fwd_a;
    data_t fwd_b;
    data_t src2;
    data_t alu_raw;
    data_t alu_sel;
    data_t alu_out;
    data_t shifter_in;
    data_t shifter_raw;
    data_t shifter_cut;
    data_t shifter_out;
    data_t result;
    logic  alu_overflow;
    logic  alu_negative;
    logic  alu_borrow;
    logic  slt_bit;

    function automatic data_t forwarded(forward_type_t sel, data_t reg_value,
                                        data_t ex_value, data_t wb_value);
        case (sel)
            fwd_ex:  return ex_value;
            fwd_wb:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

    assign fwd_a = forwarded(forward_a, id_regs.a_data, ex_regs.out, wb_data);
    assign fwd_b = forwarded(forward_b, id_regs.b_data, ex_regs.out, wb_data);

    always_comb begin
        case (id_regs.alu_src2)
            src2_sext: src2 = {{48{id_regs.imm[15]}}, id_regs.imm};
            src2_zext: src2 = {48'b0, id_regs.imm};
            default:   src2 = fwd_b;
        endcase
    end

    alu i_alu (
        .a          (fwd_a),
        .b          (src2),
        .alu_op     (id_regs.alu_op),
        .word       (id_regs.cut_alu_out32 == cut_sign32),
        .out        (alu_raw),
        .overflow   (alu_overflow),
        .zero       (),
        .negative   (alu_negative),
        .borrow_out (alu_borrow)
    );

    // Mixed signs decide by a alone, else the difference sign
    assign slt_bit = (fwd_a[63] ^ src2[63]) ? fwd_a[63] : alu_negative;

    always_comb begin
        case (id_regs.slt_type)
            slt_signed:   alu_sel = {63'b0, slt_bit};
            slt_unsigned: alu_sel = {63'b0, alu_borrow};
            default:      alu_sel = alu_raw;
        endcase
        case (id_regs.cut_alu_out32)
            cut_sign32: alu_out = {{32{alu_sel[31]}}, alu_sel[31:0]};
            default:    alu_out = alu_sel;
        endcase
    end

    // Word shifts see only the low word of rt
    assign shifter_in = id_regs.cut_shifter_out32 ? {32'b0, fwd_b[31:0]} : fwd_b;

    barrel_shifter i_shifter (
        .data        (shifter_in),
        .shamt       (id_regs.shamt),
        .shift_right (id_regs.shift_right),
        .out         (shifter_raw)
    );

    assign shifter_cut = id_regs.cut_shifter_out32
                       ? {{32{shifter_raw[31]}}, shifter_raw[31:0]} : shifter_raw;

    always_comb begin
        case (id_regs.shifter_plus32)
            plus32_left:  shifter_out = {shifter_cut[31:0], 32'b0};
            plus32_right: shifter_out = {32'b0, shifter_cut[63:32]};
            default:      shifter_out = shifter_cut;
        endcase
        if (id_regs.lui) begin
            result = {{32{id_regs.imm[15]}}, id_regs.imm, 16'b0};
        end else begin
            result = id_regs.alu_shifter_src ? shifter_out : alu_out;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ex_regs <= '0;
        end else if (flush) begin
            ex_regs <= '0;
        end else begin
            ex_regs.valid        <= id_regs.valid;
            ex_regs.out          <= result;
            ex_regs.w_regnum     <= id_regs.w_regnum;
            ex_regs.overflow     <= id_regs.valid & alu_overflow & ~id_regs.ignore_overflow;
            ex_regs.write_enable <= id_regs.write_enable;
        end
    end
endmodule

/* hw/core_wb.sv */
`timescale 1ns/10ps

module core_wb (
    input  logic               clock,
    input  logic               reset,
    input  pipe_pkg::ex_regs_t ex_regs,
    output pipe_pkg::wb_regs_t wb_regs
);
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wb_regs <= '0;
        end else begin
            wb_regs.valid    <= ex_regs.valid;
            wb_regs.data     <= ex_regs.out;
            wb_regs.w_regnum <= ex_regs.w_regnum;
            wb_regs.overflow <= ex_regs.overflow;
            // Overflow is reported but the destination keeps its value
            wb_regs.write_enable <= ex_regs.write_enable & ~ex_regs.overflow;
        end
    end
endmodule

/* hw/core_top.sv */
`timescale 1ns/10ps

module core_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             inst_valid,
    input  isa_pkg::inst_t   inst,
    input  logic             flush,
    output logic             wb_valid,
    output isa_pkg::regnum_t wb_regnum,
    output isa_pkg::data_t   wb_data,
    output logic             wb_overflow
);
    import isa_pkg::*;
    import pipe_pkg::*;

    regnum_t       ra_num;
    regnum_t       rb_num;
    data_t         ra_data;
    data_t         rb_data;
    id_regs_t      id_regs;
    ex_regs_t      ex_regs;
    wb_regs_t      wb_regs;
    forward_type_t forward_a;
    forward_type_t forward_b;

    core_id i_id (
        .clock      (clock),
        .reset      (reset),
        .flush      (flush),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ra_num     (ra_num),
        .rb_num     (rb_num),
        .ra_data    (ra_data),
        .rb_data    (rb_data),
        .id_regs    (id_regs)
    );

    regfile i_regfile (
        .clock    (clock),
        .reset    (reset),
        .ra_num   (ra_num),
        .rb_num   (rb_num),
        .ra_data  (ra_data),
        .rb_data  (rb_data),
        .w_enable (wb_regs.write_enable),
        .w_regnum (wb_regs.w_regnum),
        .w_data   (wb_regs.data)
    );

    forward_unit i_forward (
        .id_regs   (id_regs),
        .ex_regs   (ex_regs),
        .wb_regs   (wb_regs),
        .forward_a (forward_a),
        .forward_b (forward_b)
    );

    core_ex i_ex (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .id_regs   (id_regs),
        .wb_data   (wb_regs.data),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .ex_regs   (ex_regs)
    );

    core_wb i_wb (
        .clock   (clock),
        .reset   (reset),
        .ex_regs (ex_regs),
        .wb_regs (wb_regs)
    );

    assign wb_valid    = wb_regs.valid;
    assign wb_regnum   = wb_regs.w_regnum;
    assign wb_data     = wb_regs.data;
    assign wb_overflow = wb_regs.overflow;
endmodule

/* verification/core_tb.sv */
`timescale 1ns/10ps

module core_tb;
    import isa_pkg::*;

    localparam int max_tests = 8;
    localparam int max_insts = 32;

    typedef struct packed {
        int      due;
        regnum_t regnum;
        data_t   data;
        logic    overflow;
    } wb_expect_t;

    logic    clock;
    logic    reset;
    logic    inst_valid;
    inst_t   inst;
    logic    flush;
    logic    wb_valid;
    regnum_t wb_regnum;
    data_t   wb_data;
    logic    wb_overflow;

    data_t      shadow [32];     // Architectural register state
    wb_expect_t expected [$];
    string      test_name [max_tests];
    inst_t      test_prog [max_tests][max_insts];
    int         test_len [max_tests];
    bit         test_flush [max_tests]; // Flush rides on the last instruction
    int         num_tests;
    int         total_insts;
    int         cycle;
    int         errors;

    core_top i_dut (
        .clock       (clock),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .flush       (flush),
        .wb_valid    (wb_valid),
        .wb_regnum   (wb_regnum),
        .wb_data     (wb_data),
        .wb_overflow (wb_overflow)
    );

    always #10 clock = ~clock;

    function automatic data_t sext32(logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic inst_t rtype_word(funct_t fn, int rd, int rs, int rt, int sa = 0);
        return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic inst_t itype_word(opcode_t op, int rt, int rs, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic open_test(string name, bit flush_last);
        test_name[num_tests]  = name;
        test_flush[num_tests] = flush_last;
        test_len[num_tests]   = 0;
        num_tests++;
    endtask

    task automatic emit(inst_t w);
        test_prog[num_tests - 1][test_len[num_tests - 1]] = w;
        test_len[num_tests - 1]++;
        total_insts++;
    endtask

    // Builds any 64-bit constant in 16-bit pieces
    task automatic load_value(int r, data_t v);
        emit(itype_word(op_lui, r, 0, v[63:48]));
        emit(itype_word(op_ori, r, r, v[47:32]));
        emit(rtype_word(fn_dsll, r, 0, r, 16));
        emit(itype_word(op_ori, r, r, v[31:16]));
        emit(rtype_word(fn_dsll, r, 0, r, 16));
        emit(itype_word(op_ori, r, r, v[15:0]));
    endtask

    // Overflow when the extra sign bit disagrees with the result sign
    task automatic add_or_sub(input data_t x, input data_t y, input logic subtract,
                              input logic word, input logic trap,
                              output data_t res, output logic ovf);
        logic [64:0] wide;
        logic [32:0] narrow;
        wide   = subtract ? {x[63], x} - {y[63], y} : {x[63], x} + {y[63], y};
        narrow = subtract ? {x[31], x[31:0]} - {y[31], y[31:0]}
                          : {x[31], x[31:0]} + {y[31], y[31:0]};
        if (word) begin
            res = sext32(narrow[31:0]);
            ovf = trap & (narrow[32] ^ narrow[31]);
        end else begin
            res = wide[63:0];
            ovf = trap & (wide[64] ^ wide[63]);
        end
    endtask

    task automatic model_exec(input inst_t w, output data_t result, output logic ovf,
                              output regnum_t dest);
        data_t      a;
        data_t      b;
        data_t      simm;
        data_t      zimm;
        logic [4:0] sa;
        a      = shadow[w[25:21]];
        b      = shadow[w[20:16]];
        simm   = {{48{w[15]}}, w[15:0]};
        zimm   = {48'b0, w[15:0]};
        sa     = w[10:6];
        ovf    = 1'b0;
        result = '0;
        dest   = w[20:16];
        case (w[31:26])
            op_special: begin
                dest = w[15:11];
                case (w[5:0])
                    fn_add:    add_or_sub(a, b, 1'b0, 1'b1, 1'b1, result, ovf);
                    fn_addu:   add_or_sub(a, b, 1'b0, 1'b1, 1'b0, result, ovf);
                    fn_sub:    add_or_sub(a, b, 1'b1, 1'b1, 1'b1, result, ovf);
                    fn_subu:   add_or_sub(a, b, 1'b1, 1'b1, 1'b0, result, ovf);
                    fn_dadd:   add_or_sub(a, b, 1'b0, 1'b0, 1'b1, result, ovf);
                    fn_daddu:  add_or_sub(a, b, 1'b0, 1'b0, 1'b0, result, ovf);
                    fn_dsub:   add_or_sub(a, b, 1'b1, 1'b0, 1'b1, result, ovf);
                    fn_dsubu:  add_or_sub(a, b, 1'b1, 1'b0, 1'b0, result, ovf);
                    fn_and:    result = a & b;
                    fn_or:     result = a | b;
                    fn_xor:    result = a ^ b;
                    fn_nor:    result = ~(a | b);
                    fn_slt:    result = {63'b0, ($signed(a) < $signed(b))};
                    fn_sltu:   result = {63'b0, (a < b)};
                    fn_sll:    result = sext32(b[31:0] << sa);
                    fn_srl:    result = sext32(b[31:0] >> sa);
                    fn_dsll:   result = b << sa;
                    fn_dsrl:   result = b >> sa;
                    fn_dsll32: result = b << (6'd32 + {1'b0, sa});
                    fn_dsrl32: result = b >> (6'd32 + {1'b0, sa});
                    default:   result = '0;
                endcase
            end
            op_addi:   add_or_sub(a, simm, 1'b0, 1'b1, 1'b1, result, ovf);
            op_addiu:  add_or_sub(a, simm, 1'b0, 1'b1, 1'b0, result, ovf);
            op_daddi:  add_or_sub(a, simm, 1'b0, 1'b0, 1'b1, result, ovf);
            op_daddiu: add_or_sub(a, simm, 1'b0, 1'b0, 1'b0, result, ovf);
            op_slti:   result = {63'b0, ($signed(a) < $signed(simm))};
            op_sltiu:  result = {63'b0, (a < simm)};
            op_andi:   result = a & zimm;
            op_ori:    result = a | zimm;
            op_xori:   result = a ^ zimm;
            op_lui:    result = sext32({w[15:0], 16'h0000});
            default:   result = '0;
        endcase
        if (!ovf && dest != '0) begin
            shadow[dest] = result;
        end
    endtask

    task automatic compare_value(string name, data_t actual, data_t wanted);
        if (actual !== wanted) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, wanted);
            errors++;
        end
    endtask

    task automatic check_writeback();
        wb_expect_t want;
        if (expected.size() > 0 && expected[0].due == cycle) begin
            want = expected.pop_front();
            if (wb_valid !== 1'b1) begin
                $display("Missing write-back for r%0d in cycle %0d", want.regnum, cycle);
                errors++;
            end else begin
                compare_value("wb_regnum", 64'(wb_regnum), 64'(want.regnum));
                compare_value("wb_data", wb_data, want.data);
                compare_value("wb_overflow", 64'(wb_overflow), 64'(want.overflow));
            end
        end else if (wb_valid !== 1'b0) begin
            $display("Unexpected write-back to r%0d in cycle %0d", wb_regnum, cycle);
            errors++;
        end
    endtask

    // Sampled at the next edge, out of wb_regs two edges after that
    task automatic apply_cycle(logic valid, inst_t word, logic flush_now, logic dropped);
        data_t      result;
        logic       ovf;
        regnum_t    dest;
        wb_expect_t want;
        @(posedge clock);
        cycle++;
        inst_valid <= valid;
        inst       <= word;
        flush      <= flush_now;
        if (valid && !dropped) begin
            model_exec(word, result, ovf, dest);
            want.due      = cycle + 3;
            want.regnum   = dest;
            want.data     = result;
            want.overflow = ovf;
            expected.push_back(want);
        end
        @(negedge clock);
        check_writeback();
    endtask

    task automatic build_tests();
        funct_t rr_ops [12] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_daddu, fn_dsubu,
                                fn_and, fn_or, fn_xor, fn_nor, fn_dadd, fn_dsub};
        funct_t shift_ops [6] = '{fn_sll, fn_srl, fn_dsll, fn_dsrl, fn_dsll32, fn_dsrl32};
        funct_t chain_ops [4] = '{fn_daddu, fn_xor, fn_dsubu, fn_or};
        open_test("register ops", 1'b0);
        load_value(1, {$urandom, $urandom});
        load_value(2, {$urandom, $urandom});
        for (int i = 0; i < 12; i++) begin
            emit(rtype_word(rr_ops[i], 3 + i, 1, 2));
        end
        open_test("immediates", 1'b0);
        emit(itype_word(op_addi, 15, 1, 16'($urandom)));
        emit(itype_word(op_addiu, 16, 2, 16'($urandom) | 16'h8000));
        emit(itype_word(op_daddi, 17, 1, 16'($urandom)));
        emit(itype_word(op_daddiu, 18, 2, 16'hffff));
        emit(itype_word(op_andi, 19, 1, 16'($urandom) | 16'h8000));
        emit(itype_word(op_ori, 20, 2, 16'($urandom) | 16'h8000));
        emit(itype_word(op_xori, 21, 1, 16'hffff));
        emit(itype_word(op_lui, 22, 0, 16'($urandom) | 16'h8000));
        emit(itype_word(op_lui, 23, 0, 16'($urandom) & 16'h7fff));
        open_test("shifts", 1'b0);
        for (int i = 0; i < 12; i++) begin
            emit(rtype_word(shift_ops[i % 6], 24 + i % 6, 0, 1 + i / 6, int'($urandom % 32)));
        end
        open_test("set less than", 1'b0);
        load_value(1, {1'b1, 63'({$urandom, $urandom})}); // Negative
        load_value(2, {1'b0, 63'({$urandom, $urandom})}); // Positive
        emit(rtype_word(fn_slt, 25, 1, 2));
        emit(rtype_word(fn_sltu, 26, 1, 2));
        emit(rtype_word(fn_slt, 27, 2, 1));
        emit(rtype_word(fn_sltu, 28, 2, 1));
        emit(rtype_word(fn_slt, 25, 3, 4));
        emit(rtype_word(fn_sltu, 26, 3, 4));
        emit(itype_word(op_slti, 29, 1, 16'($urandom)));
        emit(itype_word(op_sltiu, 30, 2, 16'($urandom)));
        emit(itype_word(op_slti, 31, 2, 16'h8000));
        emit(itype_word(op_sltiu, 29, 1, 16'hffff));
        open_test("forwarding", 1'b0);
        emit(itype_word(op_daddiu, 5, 0, 16'($urandom)));
        emit(itype_word(op_daddiu, 6, 0, 16'($urandom)));
        emit(rtype_word(fn_daddu, 7, 5, 6));  // r5 two back, r6 one back
        emit(rtype_word(fn_daddu, 8, 5, 7));  // r5 three back
        emit(rtype_word(fn_dsubu, 9, 7, 8));
        emit(rtype_word(fn_or, 10, 7, 9));
        emit(rtype_word(fn_and, 11, 9, 8));
        emit(itype_word(op_daddiu, 0, 6, 16'h1234));
        emit(rtype_word(fn_daddu, 12, 0, 11)); // r0 must still read zero
        for (int i = 0; i < 12; i++) begin
            emit(rtype_word(chain_ops[2'($urandom)], 5 + int'($urandom % 4),
                            5 + int'($urandom % 4), 5 + int'($urandom % 4)));
        end
        open_test("overflow", 1'b0);
        load_value(3, 64'h7fff_ffff_ffff_ff00);
        emit(itype_word(op_daddiu, 4, 0, 16'h0100));
        emit(rtype_word(fn_dadd, 13, 3, 4));
        emit(itype_word(op_daddi, 13, 3, 16'h7fff));
        emit(rtype_word(fn_daddu, 14, 13, 0)); // Old r13 expected
        emit(itype_word(op_lui, 5, 0, 16'h7fff));
        emit(itype_word(op_ori, 5, 5, 16'hffff));
        emit(itype_word(op_addi, 6, 5, 16'h0001));
        emit(rtype_word(fn_add, 6, 5, 5));
        emit(itype_word(op_lui, 8, 0, 16'h8000));
        emit(rtype_word(fn_sub, 6, 8, 4));
        emit(rtype_word(fn_or, 15, 6, 0));
        open_test("flush", 1'b1);
        for (int i = 0; i < 4; i++) begin
            emit(itype_word(op_daddiu, 20 + i, 0, 16'($urandom)));
        end
        open_test("after flush", 1'b0);
        emit(rtype_word(fn_daddu, 24, 20, 21));
        emit(rtype_word(fn_daddu, 25, 22, 23));
        emit(rtype_word(fn_or, 26, 22, 0));
    endtask

    initial begin
        wait (!reset && total_insts > 0);
        #((total_insts + 50) * 20);
        $display("Timeout: the run did not finish within %0d cycles", total_insts + 50);
        $display("Test failed");
        $finish;
    end

    initial begin
        int errors_before;
        int passed;
        int failed;
        clock      = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        flush      = 1'b0;
        void'($urandom(32'h77e6));
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        build_tests();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        passed = 0;
        failed = 0;
        for (int t = 0; t < num_tests; t++) begin
            errors_before = errors;
            for (int k = 0; k < test_len[t]; k++) begin
                apply_cycle(1'b1, test_prog[t][k], test_flush[t] && (k == test_len[t] - 1),
                            test_flush[t] && (k >= test_len[t] - 2));
            end
            while (expected.size() > 0) begin
                apply_cycle(1'b0, '0, 1'b0, 1'b0);
            end
            apply_cycle(1'b0, '0, 1'b0, 1'b0); // Catches a stray write-back
            if (errors == errors_before) begin
                $display("[PASS] %s", test_name[t]);
                passed++;
            end else begin
                $display("[FAIL] %s with %0d errors", test_name[t], errors - errors_before);
                failed++;
            end
        end
        $display("Tests run: %0d, passing: %0d, failing: %0d, mismatches: %0d",
                 num_tests, passed, failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

/* sim.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/alu.sv
hw/barrel_shifter.sv
hw/regfile.sv
hw/forward_unit.sv
hw/core_id.sv
hw/core_ex.sv
hw/core_wb.sv
hw/core_top.sv
verification/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
